/* filelist.f */
+incdir+src
src/dcache_pkg.sv
src/replay_fifo.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_dcache_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_dcache_top -f filelist.f \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_dcache_top > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

/* testbench/tb_dcache_top.sv */
// Self-checking testbench for the data cache top level with a memory model; compile as sim top
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module tb_dcache_top;

   // Accept and result are both seen at falling edges, which turns a 2-cycle hit into 3
   localparam int HIT_LAT     = 3;
   localparam int SEND_LIMIT  = 2000;
   localparam int DRAIN_LIMIT = 20000;
   localparam logic [`DC_WORD_W-1:0] INIT_MUL = 64'h9E37_79B9_7F4A_7C15;
   localparam logic [`DC_WORD_W-1:0] STORE_A  = 64'hA5A5_0000_1234_5678;
   localparam logic [`DC_WORD_W-1:0] STORE_B  = 64'h0F0F_CAFE_0000_BEEF;

   logic                     clk_i = 1'b0;
   logic                     rst_n_i;
   dcache_pkg::dcache_pkt_s  dcache_pkt_i;
   logic [`DC_PTAG_W-1:0]    ptag_i;
   logic                     uncached_i;
   logic                     v_i;
   logic                     ready_o;
   logic [`DC_WORD_W-1:0]    data_o;
   logic                     v_o;
   dcache_pkg::mem_cmd_s     mem_cmd_o;
   logic                     mem_cmd_v_o;
   logic                     mem_cmd_ready_i = 1'b1;
   dcache_pkg::mem_resp_s    mem_resp_i = '0;
   logic                     mem_resp_v_i = 1'b0;
   logic                     mem_resp_yumi_o;

   // Memory model state
   logic [`DC_WORD_W-1:0]    shadow_mem [logic [`DC_PADDR_W-1:0]];
   logic                     rd_pending = 1'b0;
   logic [`DC_PADDR_W-1:0]   rd_addr;
   int                       rd_delay = 0;
   int                       rd_count = 0;
   int                       wr_count = 0;
   logic [`DC_PADDR_W-1:0]   last_rd_addr;
   logic [`DC_PADDR_W-1:0]   last_wr_addr;
   logic [`DC_WORD_W-1:0]    last_wr_data;
   logic                     gaps_on = 1'b0;
   logic                     next_ready = 1'b1;
   logic [31:0]              mem_rnd;

   // Reference and checker state
   logic [`DC_WORD_W-1:0]    ref_mem [logic [`DC_PADDR_W-1:0]];
   logic [`DC_WORD_W-1:0]    exp_q [$];
   int                       acc_q [$];
   logic [`DC_WORD_W-1:0]    exp_word;
   int                       acc_cycle;
   int                       cycle = 0;
   logic                     check_latency = 1'b0;
   logic [31:0]              lcg_state = 32'd72;
   string                    test_name = "none";
   int                       tests = 0;
   int                       checks = 0;
   int                       errors = 0;
   int                       test_err0 = 0;

   always #20 clk_i = ~clk_i;

   dcache_top u_dcache_top
   (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .dcache_pkt_i    (dcache_pkt_i),
      .ptag_i          (ptag_i),
      .uncached_i      (uncached_i),
      .v_i             (v_i),
      .ready_o         (ready_o),
      .data_o          (data_o),
      .v_o             (v_o),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

   function automatic logic [31:0] lcg_rand();
      begin
         lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
         // High state bits are the better ones, so move them low
         return {lcg_state[15:0], lcg_state[31:16]};
      end
   endfunction

   function automatic logic [`DC_WORD_W-1:0] init_word(input logic [`DC_PADDR_W-1:0] paddr);
      begin
         return {{(`DC_WORD_W-`DC_PADDR_W){1'b0}}, paddr} * INIT_MUL;
      end
   endfunction

   function automatic logic [`DC_OFFSET_W-1:0] offset_of(input logic [`DC_INDEX_W-1:0] index);
      begin
         return {{(`DC_OFFSET_W-`DC_INDEX_W-3){1'b0}}, index, 3'b000};
      end
   endfunction

   function automatic logic [`DC_WORD_W-1:0] mem_word(input logic [`DC_PADDR_W-1:0] paddr);
      begin
         if (shadow_mem.exists(paddr))
            return shadow_mem[paddr];
         else
            return init_word(paddr);
      end
   endfunction

   // Program-order expected result
   function automatic logic [`DC_WORD_W-1:0] ref_result(input logic is_store,
                                                        input logic [`DC_PADDR_W-1:0] paddr,
                                                        input logic [`DC_WORD_W-1:0] data);
      begin
         if (is_store)
         begin
            ref_mem[paddr] = data;
            return '0;
         end
         else if (ref_mem.exists(paddr))
            return ref_mem[paddr];
         else
            return init_word(paddr);
      end
   endfunction

   task automatic check_eq(input string what, input logic [`DC_WORD_W-1:0] exp,
                           input logic [`DC_WORD_W-1:0] act);
      begin
         checks++;
         if (exp !== act)
         begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
         end
      end
   endtask

   task automatic expect_count(input string what, input int exp, input int act);
      begin
         checks++;
         if (exp != act)
         begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
         end
      end
   endtask

   // Observe the memory ports where they are settled
   always @(negedge clk_i)
   begin
      if (mem_cmd_v_o && !mem_cmd_ready_i)
      begin
         errors++;
         $display("%s: mem_cmd_v_o was high while mem_cmd_ready_i was low", test_name);
      end
      if (mem_resp_yumi_o && !mem_resp_v_i)
      begin
         errors++;
         $display("%s: mem_resp_yumi_o was high with no response valid", test_name);
      end
      if (mem_cmd_v_o && (mem_cmd_o.opcode == dcache_pkg::e_dcache_op_sd))
      begin
         shadow_mem[mem_cmd_o.paddr] = mem_cmd_o.data;
         wr_count++;
         last_wr_addr = mem_cmd_o.paddr;
         last_wr_data = mem_cmd_o.data;
      end
      else if (mem_cmd_v_o)
      begin
         if (rd_pending)
         begin
            errors++;
            $display("%s: a second read command came while one was outstanding", test_name);
         end
         rd_pending   = 1'b1;
         rd_addr      = mem_cmd_o.paddr;
         last_rd_addr = mem_cmd_o.paddr;
         rd_count++;
         mem_rnd  = lcg_rand();
         rd_delay = 1 + int'(mem_rnd % 32'd6);
      end
      if (mem_resp_yumi_o)
         rd_pending = 1'b0;
      mem_rnd    = lcg_rand();
      next_ready = !gaps_on || (mem_rnd[1:0] != 2'b00);
   end

   always @(posedge clk_i)
   begin
      mem_cmd_ready_i <= next_ready;
      if (!rd_pending)
         mem_resp_v_i <= 1'b0;
      else if (rd_delay > 0)
         rd_delay--;
      else
      begin
         mem_resp_v_i <= 1'b1;
         mem_resp_i   <= '{data: mem_word(rd_addr)};
      end
   end

   // Reference on accept, compare on every result
   always @(negedge clk_i)
   begin
      cycle++;
      if (rst_n_i && v_i && ready_o)
      begin
         exp_q.push_back(ref_result(dcache_pkt_i.opcode == dcache_pkg::e_dcache_op_sd,
                                    {ptag_i, dcache_pkt_i.page_offset}, dcache_pkt_i.data));
         acc_q.push_back(cycle);
      end
      if (v_o)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("%s: v_o rose with no request outstanding", test_name);
         end
         else
         begin
            exp_word  = exp_q.pop_front();
            acc_cycle = acc_q.pop_front();
            check_eq("result", exp_word, data_o);
            if (check_latency)
               expect_count("hit latency", HIT_LAT, cycle - acc_cycle);
         end
      end
   end

   task automatic send_req(input logic is_store, input logic [`DC_PTAG_W-1:0] ptag,
                           input logic [`DC_INDEX_W-1:0] index, input logic unc,
                           input logic [`DC_WORD_W-1:0] data);
      int waited;
      begin
         waited       = 0;
         dcache_pkt_i <= '{opcode: dcache_pkg::dcache_op_e'(is_store),
                           page_offset: offset_of(index), data: data};
         ptag_i       <= ptag;
         uncached_i   <= unc;
         v_i          <= 1'b1;
         @(negedge clk_i);
         while (!ready_o && waited < SEND_LIMIT)
         begin
            @(negedge clk_i);
            waited++;
         end
         if (!ready_o)
         begin
            errors++;
            $display("%s: ready_o stayed low for %0d cycles", test_name, SEND_LIMIT);
         end
         @(posedge clk_i);
         v_i <= 1'b0;
      end
   endtask

   task automatic wait_drain();
      int waited;
      begin
         waited = 0;
         while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
         begin
            @(posedge clk_i);
            waited++;
         end
         if (exp_q.size() != 0)
         begin
            errors++;
            $display("%s: %0d results still missing after %0d cycles", test_name,
                     exp_q.size(), DRAIN_LIMIT);
         end
      end
   endtask

   task automatic start_test(input string name);
      begin
         test_name = name;
         test_err0 = errors;
      end
   endtask

   task automatic end_test();
      begin
         wait_drain();
         @(posedge clk_i);
         tests++;
         $display("%s finished with %0d errors", test_name, errors - test_err0);
      end
   endtask

   task automatic reset_test();
      begin
         start_test("reset");
         repeat (5)
         begin
            @(negedge clk_i);
            if (!ready_o || v_o || mem_cmd_v_o || mem_resp_yumi_o)
            begin
               errors++;
               $display("%s: ready_o low or a strobe high right after reset", test_name);
            end
         end
         end_test();
      end
   endtask

   task automatic hit_test();
      int rd0;
      begin
         start_test("hit");
         send_req(1'b0, 8'd1, 4'd2, 1'b0, '0);
         send_req(1'b0, 8'd1, 4'd3, 1'b0, '0);
         wait_drain();
         rd0           = rd_count;
         check_latency = 1'b1;
         send_req(1'b0, 8'd1, 4'd2, 1'b0, '0);
         send_req(1'b0, 8'd1, 4'd3, 1'b0, '0);
         send_req(1'b0, 8'd1, 4'd2, 1'b0, '0);
         wait_drain();
         check_latency = 1'b0;
         expect_count("read commands on hits", rd0, rd_count);
         end_test();
      end
   endtask

   task automatic miss_test();
      int rd0;
      begin
         start_test("miss");
         rd0 = rd_count;
         send_req(1'b0, 8'd2, 4'd5, 1'b0, '0);
         wait_drain();
         expect_count("read commands", rd0 + 1, rd_count);
         check_eq("read address", 64'({8'd2, offset_of(4'd5)}), 64'(last_rd_addr));
         end_test();
      end
   endtask

   task automatic store_test();
      int wr0;
      begin
         start_test("store");
         wr0 = wr_count;
         send_req(1'b1, 8'd3, 4'd7, 1'b0, STORE_A);
         wait_drain();
         expect_count("write commands", wr0 + 1, wr_count);
         check_eq("write address", 64'({8'd3, offset_of(4'd7)}), 64'(last_wr_addr));
         check_eq("write data", STORE_A, last_wr_data);
         send_req(1'b0, 8'd3, 4'd7, 1'b0, '0);
         send_req(1'b0, 8'd3, 4'd7, 1'b1, '0);
         // Line 2 is resident, so this store updates the data array too
         send_req(1'b1, 8'd1, 4'd2, 1'b0, STORE_B);
         send_req(1'b0, 8'd1, 4'd2, 1'b0, '0);
         end_test();
      end
   endtask

   task automatic uncached_test();
      int rd0;
      begin
         start_test("uncached");
         rd0 = rd_count;
         send_req(1'b0, 8'd0, 4'd9, 1'b1, '0);
         send_req(1'b0, 8'd0, 4'd9, 1'b1, '0);
         wait_drain();
         expect_count("read commands", rd0 + 2, rd_count);
         end_test();
      end
   endtask

   task automatic random_test();
      logic [31:0] r;
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      int          n;
      begin
         start_test("random");
         gaps_on = 1'b1;
         for (n = 0; n < 300; n++)
         begin
            r    = lcg_rand();
            r_hi = lcg_rand();
            r_lo = lcg_rand();
            if (r[12:10] == 3'd0)
               repeat (1 + r[14:13]) @(posedge clk_i);
            send_req(r[1:0] == 2'd0, {{(`DC_PTAG_W-2){1'b0}}, r[3:2]}, r[7:4],
                     r[9:8] == 2'd0, {r_hi, r_lo});
         end
         wait_drain();
         gaps_on = 1'b0;
         end_test();
      end
   endtask

   initial
   begin
      rst_n_i      = 1'b0;
      v_i          = 1'b0;
      dcache_pkt_i = '0;
      ptag_i       = '0;
      uncached_i   = 1'b0;
      repeat (10) @(posedge clk_i);
      rst_n_i <= 1'b1;
      reset_test();
      hit_test();
      miss_test();
      store_test();
      uncached_test();
      random_test();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* src/dcache_top.sv */
// Top level of the cache; connects the replay queue, both arrays and the control
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_top
   (
      input  logic                    clk_i,
      input  logic                    rst_n_i,

      input  dcache_pkg::dcache_pkt_s dcache_pkt_i,
      input  logic [`DC_PTAG_W-1:0]   ptag_i,
      input  logic                    uncached_i,
      input  logic                    v_i,
      output logic                    ready_o,

      output logic [`DC_WORD_W-1:0]   data_o,
      output logic                    v_o,

      output dcache_pkg::mem_cmd_s    mem_cmd_o,
      output logic                    mem_cmd_v_o,
      input  logic                    mem_cmd_ready_i,

      input  dcache_pkg::mem_resp_s   mem_resp_i,
      input  logic                    mem_resp_v_i,
      output logic                    mem_resp_yumi_o
   );

   dcache_pkg::req_entry_s  fifo_entry_li;
   dcache_pkg::req_entry_s  head_entry_lo;
   logic                    head_v_lo;
   logic                    head_yumi_li;
   logic                    roll_li;

   logic [`DC_INDEX_W-1:0]  rd_index_li;
   logic [`DC_INDEX_W-1:0]  wr_index_li;
   dcache_pkg::tag_entry_s  tag_rd_lo;
   dcache_pkg::tag_entry_s  tag_wr_li;
   logic                    tag_wr_en_li;
   logic [`DC_WORD_W-1:0]   data_rd_lo;
   logic [`DC_WORD_W-1:0]   data_wr_li;
   logic                    data_wr_en_li;

   assign fifo_entry_li = '{uncached: uncached_i, ptag: ptag_i, pkt: dcache_pkt_i};

   // Arrays are read at the head every cycle
   assign rd_index_li = head_entry_lo.pkt.page_offset[`DC_INDEX_W+2:3];

   replay_fifo u_replay_fifo
   (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .entry_i  (fifo_entry_li),
      .v_i      (v_i),
      .ready_o  (ready_o),
      .entry_o  (head_entry_lo),
      .v_o      (head_v_lo),
      .yumi_i   (head_yumi_li),
      .commit_i (v_o),
      .roll_i   (roll_li)
   );

   dcache_array #(.entry_t(dcache_pkg::tag_entry_s)) tag_array
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rd_index_i (rd_index_li),
      .rd_data_o  (tag_rd_lo),
      .wr_en_i    (tag_wr_en_li),
      .wr_index_i (wr_index_li),
      .wr_data_i  (tag_wr_li)
   );

   dcache_array #(.entry_t(logic [`DC_WORD_W-1:0])) data_array
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rd_index_i (rd_index_li),
      .rd_data_o  (data_rd_lo),
      .wr_en_i    (data_wr_en_li),
      .wr_index_i (wr_index_li),
      .wr_data_i  (data_wr_li)
   );

   dcache_ctrl u_dcache_ctrl
   (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .entry_i         (head_entry_lo),
      .entry_v_i       (head_v_lo),
      .entry_yumi_o    (head_yumi_li),
      .roll_o          (roll_li),
      .tag_rd_i        (tag_rd_lo),
      .data_rd_i       (data_rd_lo),
      .wr_index_o      (wr_index_li),
      .tag_wr_en_o     (tag_wr_en_li),
      .tag_wr_o        (tag_wr_li),
      .data_wr_en_o    (data_wr_en_li),
      .data_wr_o       (data_wr_li),
      .data_o          (data_o),
      .v_o             (v_o),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

endmodule

/* src/dcache_ctrl.sv */
// Cache pipeline control: hit check, write-through stores, poison and the refill FSM
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_ctrl
   (
      input  logic                    clk_i,
      input  logic                    rst_n_i,

      input  dcache_pkg::req_entry_s  entry_i,
      input  logic                    entry_v_i,
      output logic                    entry_yumi_o,
      output logic                    roll_o,

      input  dcache_pkg::tag_entry_s  tag_rd_i,
      input  logic [`DC_WORD_W-1:0]   data_rd_i,
      output logic [`DC_INDEX_W-1:0]  wr_index_o,
      output logic                    tag_wr_en_o,
      output dcache_pkg::tag_entry_s  tag_wr_o,
      output logic                    data_wr_en_o,
      output logic [`DC_WORD_W-1:0]   data_wr_o,

      output logic [`DC_WORD_W-1:0]   data_o,
      output logic                    v_o,

      output dcache_pkg::mem_cmd_s    mem_cmd_o,
      output logic                    mem_cmd_v_o,
      input  logic                    mem_cmd_ready_i,

      input  dcache_pkg::mem_resp_s   mem_resp_i,
      input  logic                    mem_resp_v_i,
      output logic                    mem_resp_yumi_o
   );

   typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT} state_e;

   state_e                  state_r;
   state_e                  state_n;

   logic                    s1_v_r;
   dcache_pkg::req_entry_s  s1_entry_r;
   logic                    s2_v_r;
   logic                    s2_fail_r;
   dcache_pkg::req_entry_s  s2_entry_r;
   logic [`DC_WORD_W-1:0]   s2_data_r;

   // One-word holding register for uncached loads
   logic                    hold_v_r;
   logic [`DC_WORD_W-1:0]   hold_data_r;

   logic                    s1_store;
   logic                    tag_hit;
   logic                    store_issue;
   logic                    hold_take;
   logic                    s1_ok;
   logic [`DC_WORD_W-1:0]   s1_data;
   logic                    fill_done;

   assign s1_store    = (s1_entry_r.pkt.opcode == dcache_pkg::e_dcache_op_sd);
   assign tag_hit     = tag_rd_i.valid & (tag_rd_i.ptag == s1_entry_r.ptag);
   assign store_issue = s1_v_r & s1_store & mem_cmd_ready_i & ~roll_o;
   assign hold_take   = s1_v_r & ~s1_store & s1_entry_r.uncached & hold_v_r & ~roll_o;

   always_comb
   begin
      if (s1_store)
      begin
         s1_ok   = mem_cmd_ready_i;
         s1_data = '0;
      end
      else if (s1_entry_r.uncached)
      begin
         s1_ok   = hold_v_r;
         s1_data = hold_data_r;
      end
      else
      begin
         s1_ok   = tag_hit;
         s1_data = data_rd_i;
      end
   end

   assign roll_o       = s2_v_r & s2_fail_r;
   assign v_o          = s2_v_r & ~s2_fail_r;
   assign data_o       = s2_data_r;
   assign entry_yumi_o = entry_v_i & (state_r == S_IDLE) & ~roll_o;

   assign fill_done       = (state_r == S_WAIT) & mem_resp_v_i;
   assign mem_resp_yumi_o = fill_done;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         S_IDLE:
            if (roll_o && (s2_entry_r.pkt.opcode == dcache_pkg::e_dcache_op_ld))
               state_n = S_SEND;
         S_SEND:
            if (mem_cmd_ready_i)
               state_n = S_WAIT;
         S_WAIT:
            if (mem_resp_v_i)
               state_n = S_IDLE;
         default:
            state_n = S_IDLE;
      endcase
   end

   // Refill read and stage-1 store never want the port together
   assign mem_cmd_v_o = store_issue | ((state_r == S_SEND) & mem_cmd_ready_i);

   always_comb
   begin
      if (state_r == S_SEND)
      begin
         mem_cmd_o.opcode = dcache_pkg::e_dcache_op_ld;
         mem_cmd_o.paddr  = {s2_entry_r.ptag, s2_entry_r.pkt.page_offset};
         mem_cmd_o.data   = '0;
      end
      else
      begin
         mem_cmd_o.opcode = dcache_pkg::e_dcache_op_sd;
         mem_cmd_o.paddr  = {s1_entry_r.ptag, s1_entry_r.pkt.page_offset};
         mem_cmd_o.data   = s1_entry_r.pkt.data;
      end
   end

   assign wr_index_o   = (state_r == S_WAIT) ? s2_entry_r.pkt.page_offset[`DC_INDEX_W+2:3]
                                             : s1_entry_r.pkt.page_offset[`DC_INDEX_W+2:3];
   assign tag_wr_en_o  = fill_done & ~s2_entry_r.uncached;
   assign tag_wr_o     = '{valid: 1'b1, ptag: s2_entry_r.ptag};
   assign data_wr_en_o = tag_wr_en_o | (store_issue & tag_hit);
   assign data_wr_o    = (state_r == S_WAIT) ? mem_resp_i.data : s1_entry_r.pkt.data;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r   <= S_IDLE;
         s1_v_r    <= 1'b0;
         s2_v_r    <= 1'b0;
         s2_fail_r <= 1'b0;
         hold_v_r  <= 1'b0;
      end
      else
      begin
         state_r   <= state_n;
         s1_v_r    <= entry_yumi_o;
         // Poison flushes stage 1
         s2_v_r    <= s1_v_r & ~roll_o;
         s2_fail_r <= ~s1_ok;
         if (fill_done && s2_entry_r.uncached)
            hold_v_r <= 1'b1;
         else if (hold_take)
            hold_v_r <= 1'b0;
      end
   end

   // Stage 2 payload stays put while the FSM works on it
   always_ff @(posedge clk_i)
   begin
      if (entry_yumi_o)
         s1_entry_r <= entry_i;
      if (s1_v_r && !roll_o)
      begin
         s2_entry_r <= s1_entry_r;
         s2_data_r  <= s1_data;
      end
      if (fill_done && s2_entry_r.uncached)
         hold_data_r <= mem_resp_i.data;
   end

endmodule

/* src/dcache_array.sv */
// Line storage with one registered, write-first read port; entry_t picks tag or data
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_array
   #(
      parameter type entry_t = logic [`DC_WORD_W-1:0]
   )
   (
      input  logic                   clk_i,
      input  logic                   rst_n_i,

      input  logic [`DC_INDEX_W-1:0] rd_index_i,
      output entry_t                 rd_data_o,

      input  logic                   wr_en_i,
      input  logic [`DC_INDEX_W-1:0] wr_index_i,
      input  entry_t                 wr_data_i
   );

   entry_t mem_r [`DC_SETS];

   // Cleared so every tag starts invalid
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < `DC_SETS; i++)
         begin
            mem_r[i] <= '0;
         end
         rd_data_o <= '0;
      end
      else
      begin
         if (wr_en_i)
            mem_r[wr_index_i] <= wr_data_i;
         // Same-index write wins over the old contents
         if (wr_en_i && (wr_index_i == rd_index_i))
            rd_data_o <= wr_data_i;
         else
            rd_data_o <= mem_r[rd_index_i];
      end
   end

endmodule

/* src/replay_fifo.sv */
// Request queue that frees entries on commit and replays from the commit point on roll
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module replay_fifo
   (
      input  logic                    clk_i,
      input  logic                    rst_n_i,

      input  dcache_pkg::req_entry_s  entry_i,
      input  logic                    v_i,
      output logic                    ready_o,

      output dcache_pkg::req_entry_s  entry_o,
      output logic                    v_o,
      input  logic                    yumi_i,

      input  logic                    commit_i,
      input  logic                    roll_i
   );

   localparam int PTR_W = `DC_FIFO_PTR_W;

   dcache_pkg::req_entry_s mem_r [`DC_FIFO_DEPTH];

   // Top bit marks the lap, so full and empty differ
   logic [PTR_W:0] wptr_r;
   logic [PTR_W:0] rptr_r;
   logic [PTR_W:0] cptr_r;
   logic [PTR_W:0] cptr_n;
   logic           enq;

   assign enq = v_i & ready_o;
   assign cptr_n = cptr_r + {{PTR_W{1'b0}}, commit_i};

   // Space comes back only when a result is committed
   assign ready_o = ~((wptr_r[PTR_W] != cptr_r[PTR_W])
                      && (wptr_r[PTR_W-1:0] == cptr_r[PTR_W-1:0]));

   assign v_o     = (rptr_r != wptr_r);
   assign entry_o = mem_r[rptr_r[PTR_W-1:0]];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_r <= '0;
         rptr_r <= '0;
         cptr_r <= '0;
      end
      else
      begin
         if (enq)
            wptr_r <= wptr_r + 1'b1;
         cptr_r <= cptr_n;
         // Rewind to the oldest uncommitted entry
         if (roll_i)
            rptr_r <= cptr_n;
         else if (yumi_i)
            rptr_r <= rptr_r + 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wptr_r[PTR_W-1:0]] <= entry_i;
   end

endmodule

/* src/dcache_pkg.sv */
// Types shared by the cache modules; other files use them through scoped names
`include "dcache_cfg.svh"

package dcache_pkg;

   typedef enum logic [0:0]
   {
      e_dcache_op_ld = 1'b0,
      e_dcache_op_sd = 1'b1
   } dcache_op_e;

   typedef struct packed
   {
      dcache_op_e                opcode;
      logic [`DC_OFFSET_W-1:0]   page_offset;
      logic [`DC_WORD_W-1:0]     data;
   } dcache_pkt_s;

   // Replay queue word, uncached flag on top
   typedef struct packed
   {
      logic                      uncached;
      logic [`DC_PTAG_W-1:0]     ptag;
      dcache_pkt_s               pkt;
   } req_entry_s;

   typedef struct packed
   {
      logic                      valid;
      logic [`DC_PTAG_W-1:0]     ptag;
   } tag_entry_s;

   typedef struct packed
   {
      dcache_op_e                opcode;
      logic [`DC_PADDR_W-1:0]    paddr;
      logic [`DC_WORD_W-1:0]     data;
   } mem_cmd_s;

   typedef struct packed
   {
      logic [`DC_WORD_W-1:0]     data;
   } mem_resp_s;

endpackage

/* src/dcache_cfg.svh */
// Size and width macros for the data cache; include before using any DC_ name
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Data word
`define DC_WORD_W 64

// Direct-mapped, one word per line
`define DC_SETS 16
`define DC_INDEX_W 4

// Index sits at offset bits 6..3, byte offset is always zero
`define DC_OFFSET_W 12

// Physical address is the tag above the page offset
`define DC_PTAG_W 8
`define DC_PADDR_W 20

// Replay queue
`define DC_FIFO_DEPTH 8
`define DC_FIFO_PTR_W 3

`endif
